//--- tb.f
logic/sd_cmd_pkg.sv
logic/sd_phy_pkg.sv
logic/cmd_serializer.sv
logic/cmd_deserializer.sv
logic/cmd_phys_controller.sv
logic/sd_cmd_phy.sv
test/sd_card_model.sv
test/tb_sd_cmd_phy.sv

//--- Makefile
TOP = tb_sd_cmd_phy

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir

//--- test/tb_sd_cmd_phy.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sd_cmd_phy
	import sd_cmd_pkg::*;
();

	localparam int NUM_TESTS = 200;
	localparam int CYCLES_PER_TEST = 400;
	localparam int CLK_PERIOD = 20;
	localparam int CHECK_BITS = $bits(sd_response_t);

	logic sd_clock = 1'b0;
	logic reset = 1'b1;
	sd_command_t cmd = '0;
	logic cmd_valid = 1'b0;
	logic cmd_ready;
	sd_response_t resp;
	logic resp_valid;
	logic resp_ready = 1'b0;
	logic cmd_out;
	logic cmd_oe;
	logic cmd_in;

	logic reply_enable = 1'b0;
	logic reply_long = 1'b0;
	logic [LONG_RESP_BITS-1:0] reply_frame = '0;
	logic [5:0] reply_delay = 6'd4;
	logic [CMD_FRAME_BITS-1:0] last_frame;
	int oe_cycles;
	int frame_count;

	logic [15:0] lfsr = 16'd29;
	int errors = 0;
	int issued = 0;
	int answered = 0;

	always #(CLK_PERIOD / 2) sd_clock = ~sd_clock;

	sd_cmd_phy i_sd_cmd_phy (
		.sd_clock(sd_clock),
		.reset(reset),
		.cmd(cmd),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.resp(resp),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready),
		.cmd_out(cmd_out),
		.cmd_oe(cmd_oe),
		.cmd_in(cmd_in)
	);

	sd_card_model i_card (
		.sd_clock(sd_clock),
		.reset(reset),
		.cmd_out(cmd_out),
		.cmd_oe(cmd_oe),
		.cmd_line(cmd_in),
		.reply_enable(reply_enable),
		.reply_long(reply_long),
		.reply_frame(reply_frame),
		.reply_delay(reply_delay),
		.last_frame(last_frame),
		.oe_cycles(oe_cycles),
		.frame_count(frame_count)
	);

	// x^16 + x^14 + x^13 + x^11 + 1, shifting right
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? (s >> 1) ^ 16'hB400 : s >> 1;
	endfunction

	task automatic take_bits(input int count, output logic [63:0] value);
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			value = {value[62:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// crc7 of bits[msb:lsb], msb first, taps at x^3 and x^0
	function automatic logic [6:0] frame_crc7(input logic [LONG_RESP_BITS-1:0] bits,
		input int msb, input int lsb);
		logic [6:0] r;
		logic fb;
		r = '0;
		for (int i = msb; i >= lsb; i--)
		begin
			fb = bits[i] ^ r[6];
			r = {r[5:3], r[2] ^ fb, r[1:0], fb};
		end
		return r;
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		errors++;
	endtask

	task automatic check_value(input string name, input logic [CHECK_BITS-1:0] got,
		input logic [CHECK_BITS-1:0] want);
		assert (got === want)
		else
			report_failure($sformatf("FAILED %s: got %h, expected %h", name, got, want));
	endtask

	task automatic run_test(input int n);
		logic [63:0] r;
		sd_command_t c;
		logic [LONG_RESP_BITS-1:0] frame;
		logic [CMD_FRAME_BITS-1:0] want_frame;
		sd_response_t want;
		sd_response_t first;
		logic silent;
		logic flip;
		logic seen;
		logic taken;
		int pos;
		int waited;
		int errors_before;
		int frames_before;
		string action;

		errors_before = errors;
		frames_before = frame_count;
		take_bits(6, r);
		c.cmd_index = r[5:0];
		take_bits(32, r);
		c.argument = r[31:0];
		take_bits(2, r);
		c.resp_kind = r[1:0] == 2'd2 ? resp_long : (r[1:0] == 2'd0 ? resp_none : resp_short);
		take_bits(3, r);
		silent = r[2:0] == 3'd0;
		flip = r[2:0] == 3'd1;
		take_bits(6, r);
		reply_delay = 6'd4 + (r[5:0] % 6'd47);   // 4 to 50

		frame = '0;
		for (int k = 0; k < 3; k++)
		begin
			take_bits(64, r);
			frame = {frame[LONG_RESP_BITS-65:0], r};
		end
		if (c.resp_kind == resp_long)
		begin
			frame[135:134] = 2'b00;
			frame[7:0] = {frame_crc7(frame, 127, 8), 1'b1};
		end
		else
		begin
			frame[135:46] = '0;   // short frame plus start and direction
			frame[7:0] = {frame_crc7(frame, 47, 8), 1'b1};
		end
		if (flip)
		begin
			take_bits(8, r);
			pos = int'(r[7:0]) % (c.resp_kind == resp_long ? 128 : 47);
			frame[pos] = ~frame[pos];
		end

		want = '0;
		if (c.resp_kind != resp_none)
		begin
			if (silent)
				want.timeout = 1'b1;
			else
			begin
				want.payload = frame;
				want.crc_error = flip;
			end
		end
		want_frame = {1'b0, 1'b1, c.cmd_index, c.argument, 7'd0, 1'b1};
		want_frame[7:1] = frame_crc7(LONG_RESP_BITS'(want_frame), 47, 8);

		reply_enable = c.resp_kind != resp_none && !silent;
		reply_long = c.resp_kind == resp_long;
		reply_frame = frame;
		cmd = c;
		cmd_valid = 1'b1;
		while (!cmd_ready)
			@(negedge sd_clock);
		issued++;
		@(negedge sd_clock);
		cmd_valid = 1'b0;

		seen = 1'b0;
		taken = 1'b0;
		waited = 0;
		while (!taken && waited < CYCLES_PER_TEST)
		begin
			take_bits(2, r);
			resp_ready = r[1:0] != 2'd0;   // held off about one cycle in four
			assert (!cmd_ready)
			else
				report_failure($sformatf("cmd_ready high before response taken, test %0d", n));
			if (resp_valid)
			begin
				if (seen)
					check_value("resp (held)", CHECK_BITS'(resp), CHECK_BITS'(first));
				first = resp;
				seen = 1'b1;
				taken = resp_ready;
			end
			waited++;
			@(negedge sd_clock);
		end
		resp_ready = 1'b0;

		assert (taken)
		else
			report_failure($sformatf("no response within %0d cycles, test %0d",
				CYCLES_PER_TEST, n));
		if (taken)
		begin
			answered++;
			assert (!resp_valid)
			else
				report_failure($sformatf("response repeated after it was taken, test %0d", n));
			check_value("resp.payload", CHECK_BITS'(first.payload), CHECK_BITS'(want.payload));
			check_value("resp.timeout", CHECK_BITS'(first.timeout), CHECK_BITS'(want.timeout));
			check_value("resp.crc_error", CHECK_BITS'(first.crc_error),
				CHECK_BITS'(want.crc_error));
		end
		assert (frame_count == frames_before + 1)
		else
			report_failure($sformatf("card saw no single command frame, test %0d", n));
		check_value("cmd_out frame", CHECK_BITS'(last_frame), CHECK_BITS'(want_frame));
		check_value("cmd_oe cycles", CHECK_BITS'(oe_cycles), CHECK_BITS'(CMD_FRAME_BITS));

		if (c.resp_kind == resp_none)
			action = "no response";
		else if (silent)
			action = "card silent";
		else if (flip)
			action = "bit flipped";
		else
			action = "card replied";
		$display("test %0d: cmd %0d, %s, %s", n, c.cmd_index, action,
			errors == errors_before ? "ok" : "errors");
	endtask

	initial
	begin
		repeat (5) @(negedge sd_clock);
		assert (!cmd_ready && !cmd_oe && !resp_valid && cmd_out)
		else
			report_failure("outputs not in their reset state");
		reset = 1'b0;
		@(negedge sd_clock);
		assert (cmd_ready)
		else
			report_failure("cmd_ready did not rise in the first cycle after reset");

		for (int n = 0; n < NUM_TESTS; n++)
			run_test(n);

		assert (issued == answered)
		else
			report_failure("commands lost or duplicated");
		$display("%0d tests, %0d commands, %0d responses, %0d errors",
			NUM_TESTS, issued, answered, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		#(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, run stopped",
			NUM_TESTS * CYCLES_PER_TEST);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/sd_card_model.sv
`timescale 1ns/1ps
`default_nettype none

module sd_card_model
	import sd_cmd_pkg::*;
(
	input wire logic sd_clock,
	input wire logic reset,

	// host pad
	input wire logic cmd_out,
	input wire logic cmd_oe,
	output logic cmd_line,

	// reply set up before the command goes out
	input wire logic reply_enable,
	input wire logic reply_long,
	input wire logic [LONG_RESP_BITS-1:0] reply_frame,
	input wire logic [5:0] reply_delay,

	// last command as seen on the line
	output logic [CMD_FRAME_BITS-1:0] last_frame,
	output int oe_cycles,
	output int frame_count = 0
);

	logic [CMD_FRAME_BITS-1:0] shift_in;
	logic [LONG_RESP_BITS-1:0] frame_q;
	int oe_run = 0;
	int wait_left;
	int bit_index;
	logic waiting = 1'b0;
	logic sending = 1'b0;
	logic drive_en = 1'b0;
	logic drive_bit = 1'b1;

	assign cmd_line = drive_en ? drive_bit : 1'b1;   // pull-up when released

	always @(negedge sd_clock)
	begin
		if (reset)
		begin
			oe_run = 0;
			waiting = 1'b0;
			sending = 1'b0;
			drive_en <= 1'b0;
			drive_bit <= 1'b1;
			frame_count <= 0;
		end
		else if (cmd_oe)
		begin
			shift_in = {shift_in[CMD_FRAME_BITS-2:0], cmd_out};
			oe_run = oe_run + 1;
		end
		else
		begin
			if (oe_run != 0)
			begin
				// first cycle after the command end bit
				last_frame <= shift_in;
				oe_cycles <= oe_run;
				frame_count <= frame_count + 1;
				oe_run = 0;
				if (reply_enable)
				begin
					frame_q = reply_frame;
					bit_index = reply_long ? LONG_RESP_BITS - 1 : SHORT_RESP_BITS - 1;
					wait_left = int'(reply_delay);
					waiting = 1'b1;
				end
			end
			else if (waiting)
			begin
				wait_left = wait_left - 1;
				if (wait_left == 0)
				begin
					waiting = 1'b0;
					sending = 1'b1;
				end
			end

			if (sending)
			begin
				drive_en <= 1'b1;
				drive_bit <= frame_q[bit_index];   // msb first
				if (bit_index == 0)
					sending = 1'b0;
				else
					bit_index = bit_index - 1;
			end
			else
				drive_en <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- logic/sd_cmd_phy.sv
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_phy
	import sd_cmd_pkg::*;
(
	input wire logic sd_clock,
	input wire logic reset,

	input wire sd_command_t cmd,
	input wire logic cmd_valid,
	output logic cmd_ready,

	output sd_response_t resp,
	output logic resp_valid,
	input wire logic resp_ready,

	output logic cmd_out,
	output logic cmd_oe,
	input wire logic cmd_in
);

	sd_command_t tx_cmd;
	logic tx_valid;
	logic tx_ready;
	logic tx_done;
	logic rx_arm;
	logic rx_long;
	sd_response_t rx_result;
	logic rx_valid;
	logic rx_ready;

	cmd_phys_controller i_cmd_phys_controller (
		.sd_clock(sd_clock),
		.reset(reset),
		.cmd(cmd),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.resp(resp),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready),
		.tx_cmd(tx_cmd),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.tx_done(tx_done),
		.rx_arm(rx_arm),
		.rx_long(rx_long),
		.rx_result(rx_result),
		.rx_valid(rx_valid),
		.rx_ready(rx_ready)
	);

	cmd_serializer i_cmd_serializer (
		.sd_clock(sd_clock),
		.reset(reset),
		.tx_cmd(tx_cmd),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.tx_done(tx_done),
		.cmd_out(cmd_out),
		.cmd_oe(cmd_oe)
	);

	cmd_deserializer i_cmd_deserializer (
		.sd_clock(sd_clock),
		.reset(reset),
		.rx_arm(rx_arm),
		.rx_long(rx_long),
		.cmd_in(cmd_in),
		.rx_result(rx_result),
		.rx_valid(rx_valid),
		.rx_ready(rx_ready)
	);

endmodule

`default_nettype wire

//--- logic/cmd_phys_controller.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_phys_controller
	import sd_cmd_pkg::*;
	import sd_phy_pkg::*;
(
	input wire logic sd_clock,
	input wire logic reset,

	// host side
	input wire sd_command_t cmd,
	input wire logic cmd_valid,
	output logic cmd_ready,
	output sd_response_t resp,
	output logic resp_valid,
	input wire logic resp_ready,

	// serializer
	output sd_command_t tx_cmd,
	output logic tx_valid,
	input wire logic tx_ready,
	input wire logic tx_done,

	// deserializer
	output logic rx_arm,
	output logic rx_long,
	input wire sd_response_t rx_result,
	input wire logic rx_valid,
	output logic rx_ready
);

	ctrl_state_t state;
	resp_kind_t req_kind;
	logic host_ready;
	logic [TURNAROUND_COUNT_BITS-1:0] ta_count;
	sd_response_t resp_q;

	// host transfer and serializer load happen in the same cycle
	assign cmd_ready = host_ready && tx_ready;
	assign tx_valid = host_ready && cmd_valid;
	assign tx_cmd = cmd;

	assign rx_arm = state == wait_response
		&& ta_count == TURNAROUND_COUNT_BITS'(TURNAROUND_CYCLES);
	assign rx_long = req_kind == resp_long;
	assign rx_ready = state == wait_response;

	assign resp_valid = state == send_response;
	assign resp = resp_q;

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			state <= idle;
			req_kind <= resp_none;
			host_ready <= 1'b0;
			ta_count <= '0;
		end
		else
		begin
			case (state)
				idle:
				begin
					if (cmd_valid && cmd_ready)
					begin
						req_kind <= cmd.resp_kind;
						host_ready <= 1'b0;
						state <= send_command;
					end
					else
						host_ready <= 1'b1;
				end
				send_command:
				begin
					if (tx_done)
					begin
						ta_count <= '0;
						if (req_kind == resp_none)
							state <= send_response;   // nothing to wait for
						else
							state <= wait_response;
					end
				end
				wait_response:
				begin
					// saturates one past the arm point
					if (ta_count != TURNAROUND_COUNT_BITS'(TURNAROUND_CYCLES + 1))
						ta_count <= ta_count + 1'b1;
					if (rx_valid)
						state <= send_response;
				end
				send_response:
				begin
					if (resp_ready)
					begin
						host_ready <= 1'b1;
						state <= idle;
					end
				end
				default:
					state <= idle;
			endcase
		end
	end

	always_ff @(posedge sd_clock)
	begin
		if (state == send_command && tx_done && req_kind == resp_none)
			resp_q <= '0;
		else if (state == wait_response && rx_valid)
			resp_q <= rx_result;
	end

endmodule

`default_nettype wire

//--- logic/cmd_deserializer.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_deserializer
	import sd_cmd_pkg::*;
	import sd_phy_pkg::*;
(
	input wire logic sd_clock,
	input wire logic reset,

	input wire logic rx_arm,
	input wire logic rx_long,
	input wire logic cmd_in,

	output sd_response_t rx_result,
	output logic rx_valid,
	input wire logic rx_ready
);

	logic armed;       // waiting for start bit
	logic capturing;
	logic is_long;
	logic held_valid;
	logic [TIMEOUT_COUNT_BITS-1:0] wait_count;
	logic [RESP_COUNT_BITS-1:0] bit_count;
	logic [RESP_COUNT_BITS-1:0] last_index;
	logic [LONG_RESP_BITS-1:0] shift_q;
	logic [LONG_RESP_BITS-1:0] frame_now;
	logic [6:0] crc_calc;
	logic frame_done;
	logic timeout_now;
	logic done_now;
	sd_response_t fresh;
	sd_response_t held;

	// includes the bit on the line this cycle
	assign frame_now = {shift_q[LONG_RESP_BITS-2:0], cmd_in};

	assign last_index = is_long ? RESP_COUNT_BITS'(LONG_RESP_BITS - 1)
		: RESP_COUNT_BITS'(SHORT_RESP_BITS - 1);
	assign frame_done = capturing && bit_count == last_index;
	assign timeout_now = armed && cmd_in
		&& wait_count == TIMEOUT_COUNT_BITS'(RESPONSE_TIMEOUT - 1);
	assign done_now = frame_done || timeout_now;

	// short: bits 47:8, long: bits 127:8
	assign crc_calc = crc7(frame_now >> 8,
		is_long ? LONG_RESP_BITS - 16 : SHORT_RESP_BITS - 8);

	always_comb
	begin
		fresh = '0;
		if (timeout_now)
			fresh.timeout = 1'b1;
		else
		begin
			fresh.payload = frame_now;
			fresh.crc_error = crc_calc != frame_now[7:1] || !frame_now[0];
		end
	end

	assign rx_valid = held_valid || done_now;
	assign rx_result = held_valid ? held : fresh;

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			armed <= 1'b0;
			capturing <= 1'b0;
			held_valid <= 1'b0;
			wait_count <= '0;
			bit_count <= '0;
		end
		else
		begin
			if (rx_arm)
			begin
				armed <= 1'b1;
				wait_count <= '0;
			end
			else if (armed)
			begin
				if (!cmd_in)
				begin
					armed <= 1'b0;
					capturing <= 1'b1;
					bit_count <= RESP_COUNT_BITS'(1);
				end
				else if (timeout_now)
					armed <= 1'b0;
				else
					wait_count <= wait_count + 1'b1;
			end
			else if (capturing)
			begin
				bit_count <= bit_count + 1'b1;
				if (frame_done)
					capturing <= 1'b0;
			end

			if (done_now && !rx_ready)
				held_valid <= 1'b1;
			else if (held_valid && rx_ready)
				held_valid <= 1'b0;
		end
	end

	always_ff @(posedge sd_clock)
	begin
		if (rx_arm)
		begin
			shift_q <= '0;   // keeps short payload upper bits zero
			is_long <= rx_long;
		end
		else if ((armed && !cmd_in) || capturing)
			shift_q <= frame_now;
		if (done_now && !rx_ready)
			held <= fresh;
	end

endmodule

`default_nettype wire

//--- logic/cmd_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_serializer
	import sd_cmd_pkg::*;
(
	input wire logic sd_clock,
	input wire logic reset,

	input wire sd_command_t tx_cmd,
	input wire logic tx_valid,
	output logic tx_ready,
	output logic tx_done,

	output logic cmd_out,
	output logic cmd_oe
);

	sd_cmd_frame_t frame;
	logic [CMD_FRAME_BITS-1:0] shift_q;
	logic [FRAME_COUNT_BITS-1:0] bit_count;
	logic busy;
	logic load;

	always_comb
	begin
		frame.start_bit = 1'b0;
		frame.direction = 1'b1;
		frame.cmd_index = tx_cmd.cmd_index;
		frame.argument = tx_cmd.argument;
		// crc covers start, direction, index and argument
		frame.crc = crc7({96'd0, 2'b01, tx_cmd.cmd_index, tx_cmd.argument},
			CMD_FRAME_BITS - 8);
		frame.stop_bit = 1'b1;
	end

	assign tx_ready = !busy;
	assign load = tx_valid && tx_ready;

	assign cmd_oe = busy;
	assign cmd_out = busy ? shift_q[CMD_FRAME_BITS-1] : 1'b1;   // idle line high
	assign tx_done = busy && bit_count == FRAME_COUNT_BITS'(CMD_FRAME_BITS - 1);

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			bit_count <= '0;
		end
		else if (load)
		begin
			busy <= 1'b1;
			bit_count <= '0;
		end
		else if (busy)
		begin
			bit_count <= bit_count + 1'b1;
			if (tx_done)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge sd_clock)
	begin
		if (load)
			shift_q <= frame;
		else if (busy)
			shift_q <= shift_q << 1;   // msb first
	end

endmodule

`default_nettype wire

//--- logic/sd_phy_pkg.sv
`default_nettype none

package sd_phy_pkg;

	// cycles from cmd_oe falling to receiver armed
	localparam int TURNAROUND_CYCLES = 2;
	// armed cycles allowed before the start bit
	localparam int RESPONSE_TIMEOUT = 64;

	localparam int TURNAROUND_COUNT_BITS = $clog2(TURNAROUND_CYCLES + 2);
	localparam int TIMEOUT_COUNT_BITS = $clog2(RESPONSE_TIMEOUT);

	typedef enum logic [1:0] {
		idle          = 2'd0,
		send_command  = 2'd1,
		wait_response = 2'd2,
		send_response = 2'd3
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- logic/sd_cmd_pkg.sv
`default_nettype none

package sd_cmd_pkg;

	localparam int CMD_FRAME_BITS = 48;
	localparam int SHORT_RESP_BITS = 48;
	localparam int LONG_RESP_BITS = 136;

	localparam int FRAME_COUNT_BITS = $clog2(CMD_FRAME_BITS);
	localparam int RESP_COUNT_BITS = $clog2(LONG_RESP_BITS + 1);

	typedef enum logic [1:0] {
		resp_none  = 2'd0,
		resp_short = 2'd1,   // R1/R3/R6/R7
		resp_long  = 2'd2    // R2
	} resp_kind_t;

	typedef struct packed {
		logic [5:0] cmd_index;
		logic [31:0] argument;
		resp_kind_t resp_kind;
	} sd_command_t;

	// bit order as sent on the line, msb first
	typedef struct packed {
		logic start_bit;
		logic direction;     // 1 = host to card
		logic [5:0] cmd_index;
		logic [31:0] argument;
		logic [6:0] crc;
		logic stop_bit;
	} sd_cmd_frame_t;

	typedef struct packed {
		logic [LONG_RESP_BITS-1:0] payload;
		logic timeout;
		logic crc_error;
	} sd_response_t;

	// x^7 + x^3 + 1 over data[count-1:0], msb first
	function automatic logic [6:0] crc7(input logic [LONG_RESP_BITS-1:0] data,
		input int unsigned count);
		logic [6:0] crc;
		logic feedback;
		crc = 7'd0;
		for (int i = LONG_RESP_BITS - 1; i >= 0; i--)
		begin
			if (i < count)
			begin
				feedback = data[i] ^ crc[6];
				crc = {crc[5:0], 1'b0};
				if (feedback)
					crc = crc ^ 7'h09;
			end
		end
		return crc;
	endfunction

endpackage

`default_nettype wire
